// ==== rvIsaPkg.sv ====
package rvIsaPkg;

   localparam int xlen = 64;
   localparam int numRegs = 32;
   localparam int shamtWidth = 6;         // RV64 shifts use six bits of shift amount

   typedef logic [4:0] regIdx_t;
   typedef logic [xlen-1:0] xdata_t;
   typedef logic [31:0] instr_t;

   // Only the three major opcodes this pipeline executes
   typedef enum logic [6:0] {
      opOp    = 7'b0110011,
      opOpImm = 7'b0010011,
      opLui   = 7'b0110111
   } opcode_t;

   typedef enum logic [3:0] {
      aluAdd,
      aluSub,
      aluSll,
      aluSlt,
      aluSltu,
      aluXor,
      aluSrl,
      aluSra,
      aluOr,
      aluAnd,
      aluPassB                            // Operand B straight through for LUI
   } aluOp_t;

   localparam logic [2:0] f3AddSub = 3'b000;
   localparam logic [2:0] f3Sll    = 3'b001;
   localparam logic [2:0] f3Slt    = 3'b010;
   localparam logic [2:0] f3Sltu   = 3'b011;
   localparam logic [2:0] f3Xor    = 3'b100;
   localparam logic [2:0] f3Srl    = 3'b101;
   localparam logic [2:0] f3Or     = 3'b110;
   localparam logic [2:0] f3And    = 3'b111;

   localparam logic [6:0] f7Base = 7'b0000000;
   localparam logic [6:0] f7Alt  = 7'b0100000;   // Selects sub and sra

   // Immediate shifts keep only funct6 since bit 25 belongs to the shift amount
   localparam logic [5:0] f6Base = 6'b000000;
   localparam logic [5:0] f6Alt  = 6'b010000;

endpackage

// ==== pipePkg.sv ====
package pipePkg;

   // Everything execute needs, captured at the end of decode
   typedef struct packed {
      rvIsaPkg::regIdx_t rd;
      rvIsaPkg::regIdx_t rs1Idx;
      rvIsaPkg::regIdx_t rs2Idx;
      rvIsaPkg::xdata_t  rs1Val;
      rvIsaPkg::xdata_t  rs2Val;
      rvIsaPkg::xdata_t  imm;             // Already sign extended
      logic              useImm;
      rvIsaPkg::aluOp_t  aluOp;
      logic              writesRd;
      logic              illegal;
   } decodedOp_t;

   // Result record held in the writeback stage and shown at the top level
   typedef struct packed {
      logic              valid;
      logic              illegal;
      rvIsaPkg::regIdx_t rd;
      rvIsaPkg::xdata_t  result;
      logic              writesRd;
   } wbRecord_t;

   typedef struct packed {
      logic              en;
      rvIsaPkg::regIdx_t rd;
      rvIsaPkg::xdata_t  data;
   } regWrite_t;

endpackage

// ==== registerFile.sv ====
`timescale 1ns/1ns

module registerFile (
   input  logic               clk,
   input  logic               reset,
   input  rvIsaPkg::regIdx_t  rs1Idx,
   input  rvIsaPkg::regIdx_t  rs2Idx,
   input  pipePkg::regWrite_t write,
   output rvIsaPkg::xdata_t   rs1Val,
   output rvIsaPkg::xdata_t   rs2Val
);
   import rvIsaPkg::*;

   xdata_t regs [numRegs];
   logic   wrEn;

   // x0 is never written, so its entry keeps the value reset gave it
   assign wrEn = write.en && (write.rd != '0);

   always_ff @(posedge clk) begin
      if (reset) begin
         for (int i = 0; i < numRegs; i++) begin
            regs[i] <= '0;
         end
      end else if (wrEn) begin
         regs[write.rd] <= write.data;
      end
   end

   // A write landing this cycle is visible to the reader right away
   always_comb begin
      if (wrEn && (write.rd == rs1Idx)) begin
         rs1Val = write.data;
      end else begin
         rs1Val = regs[rs1Idx];
      end
   end

   always_comb begin
      if (wrEn && (write.rd == rs2Idx)) begin
         rs2Val = write.data;
      end else begin
         rs2Val = regs[rs2Idx];
      end
   end

   // Holds only as long as no write path ever reaches entry 0
   x0ReadsZero: assert property (@(posedge clk) disable iff (reset)
      ((rs1Idx != '0) || (rs1Val == '0)) && ((rs2Idx != '0) || (rs2Val == '0)))
      else $error("Register x0 read back a nonzero value");

endmodule

// ==== instrDecoder.sv ====
`timescale 1ns/1ns

module instrDecoder (
   input  rvIsaPkg::instr_t    instr,
   output rvIsaPkg::regIdx_t   rs1Idx,
   output rvIsaPkg::regIdx_t   rs2Idx,
   input  rvIsaPkg::xdata_t    rs1Val,
   input  rvIsaPkg::xdata_t    rs2Val,
   output pipePkg::decodedOp_t decoded
);
   import rvIsaPkg::*;

   opcode_t    opcode;
   regIdx_t    rd;
   logic [2:0] funct3;
   logic [6:0] funct7;
   logic [5:0] funct6;
   xdata_t     iImm;
   xdata_t     uImm;

   // Same mapping for OP and OP-IMM, alt picks sub or sra
   function automatic aluOp_t opFromFunct3(input logic [2:0] f3, input logic alt);
      case (f3)
         f3AddSub: opFromFunct3 = alt ? aluSub : aluAdd;
         f3Sll:    opFromFunct3 = aluSll;
         f3Slt:    opFromFunct3 = aluSlt;
         f3Sltu:   opFromFunct3 = aluSltu;
         f3Xor:    opFromFunct3 = aluXor;
         f3Srl:    opFromFunct3 = alt ? aluSra : aluSrl;
         f3Or:     opFromFunct3 = aluOr;
         default:  opFromFunct3 = aluAnd;
      endcase
   endfunction

   assign opcode = opcode_t'(instr[6:0]);
   assign rd     = instr[11:7];
   assign funct3 = instr[14:12];
   assign rs1Idx = instr[19:15];
   assign rs2Idx = instr[24:20];
   assign funct7 = instr[31:25];
   assign funct6 = instr[31:26];

   assign iImm = {{(xlen-12){instr[31]}}, instr[31:20]};
   assign uImm = {{(xlen-32){instr[31]}}, instr[31:12], 12'b0};   // LUI sign extends on RV64

   always_comb begin
      decoded        = '0;
      decoded.rd     = rd;
      decoded.rs1Idx = rs1Idx;
      decoded.rs2Idx = rs2Idx;
      decoded.rs1Val = rs1Val;
      decoded.rs2Val = rs2Val;
      decoded.imm    = iImm;
      decoded.aluOp  = aluAdd;

      case (opcode)
         opOp: begin
            decoded.aluOp = opFromFunct3(funct3, funct7 == f7Alt);
            if ((funct7 != f7Base) && (funct7 != f7Alt)) begin
               decoded.illegal = 1'b1;
            end else if ((funct7 == f7Alt) && (funct3 != f3AddSub) && (funct3 != f3Srl)) begin
               decoded.illegal = 1'b1;                  // Only sub and sra have an alt form
            end
         end
         opOpImm: begin
            decoded.useImm = 1'b1;
            decoded.aluOp  = opFromFunct3(funct3, (funct3 == f3Srl) && (funct6 == f6Alt));
            if ((funct3 == f3Sll) && (funct6 != f6Base)) begin
               decoded.illegal = 1'b1;
            end else if ((funct3 == f3Srl) && (funct6 != f6Base) && (funct6 != f6Alt)) begin
               decoded.illegal = 1'b1;
            end
         end
         opLui: begin
            decoded.useImm = 1'b1;
            decoded.imm    = uImm;
            decoded.aluOp  = aluPassB;
         end
         default: begin
            decoded.illegal = 1'b1;
         end
      endcase

      decoded.writesRd = !decoded.illegal;
   end

endmodule

// ==== executeStage.sv ====
`timescale 1ns/1ns

module executeStage (
   input  pipePkg::decodedOp_t op,
   input  logic                opValid,
   input  pipePkg::regWrite_t  wbWrite,
   output pipePkg::wbRecord_t  result
);
   import rvIsaPkg::*;

   xdata_t                opA;
   xdata_t                rs2Fwd;
   xdata_t                opB;
   xdata_t                aluOut;
   logic [shamtWidth-1:0] shamt;

   // The writeback record is one instruction ahead, so its data is newer than the file read
   assign opA    = (wbWrite.en && (wbWrite.rd == op.rs1Idx)) ? wbWrite.data : op.rs1Val;
   assign rs2Fwd = (wbWrite.en && (wbWrite.rd == op.rs2Idx)) ? wbWrite.data : op.rs2Val;
   assign opB    = op.useImm ? op.imm : rs2Fwd;
   assign shamt  = opB[shamtWidth-1:0];

   always_comb begin
      case (op.aluOp)
         aluAdd:   aluOut = opA + opB;
         aluSub:   aluOut = opA - opB;
         aluSll:   aluOut = opA << shamt;
         aluSlt:   aluOut = {{(xlen-1){1'b0}}, $signed(opA) < $signed(opB)};
         aluSltu:  aluOut = {{(xlen-1){1'b0}}, opA < opB};
         aluXor:   aluOut = opA ^ opB;
         aluSrl:   aluOut = opA >> shamt;
         aluSra:   aluOut = xdata_t'($signed(opA) >>> shamt);
         aluOr:    aluOut = opA | opB;
         aluAnd:   aluOut = opA & opB;
         aluPassB: aluOut = opB;
         default:  aluOut = '0;
      endcase
   end

   always_comb begin
      result.valid    = opValid;
      result.illegal  = op.illegal;
      result.rd       = op.rd;
      result.result   = aluOut;
      result.writesRd = op.writesRd;
   end

   // Decode clears writesRd for illegal words and the stage register must keep it that way
   always_comb begin
      if (opValid) begin
         assert (!(op.illegal && op.writesRd))
            else $error("Illegal instruction reached execute with a register write");
      end
   end

endmodule

// ==== pipeStageReg.sv ====
`timescale 1ns/1ns

module pipeStageReg #(
   parameter type payload_t = logic
) (
   input  logic     clk,
   input  logic     reset,
   input  logic     inValid,
   input  payload_t inData,
   output logic     outValid,
   output payload_t outData
);

   always_ff @(posedge clk) begin
      if (reset) begin
         outValid <= 1'b0;
      end else begin
         outValid <= inValid;
      end
   end

   // Payload is only meaningful while outValid is high
   always_ff @(posedge clk) begin
      outData <= inData;
   end

endmodule

// ==== aluPipeline.sv ====
`timescale 1ns/1ns

module aluPipeline (
   input  logic               clk,
   input  logic               reset,
   input  logic               instrValid,
   input  rvIsaPkg::instr_t   instr,
   output pipePkg::wbRecord_t wb
);
   import rvIsaPkg::*;
   import pipePkg::*;

   regIdx_t    rs1Idx;
   regIdx_t    rs2Idx;
   xdata_t     rs1Val;
   xdata_t     rs2Val;
   decodedOp_t decoded;
   decodedOp_t exOp;
   logic       exValid;
   wbRecord_t  exResult;
   wbRecord_t  wbData;
   logic       wbValid;
   regWrite_t  regWrite;

   instrDecoder decoder (
      .instr   (instr),
      .rs1Idx  (rs1Idx),
      .rs2Idx  (rs2Idx),
      .rs1Val  (rs1Val),
      .rs2Val  (rs2Val),
      .decoded (decoded)
   );

   registerFile regFile (
      .clk    (clk),
      .reset  (reset),
      .rs1Idx (rs1Idx),
      .rs2Idx (rs2Idx),
      .write  (regWrite),
      .rs1Val (rs1Val),
      .rs2Val (rs2Val)
   );

   pipeStageReg #(.payload_t(decodedOp_t)) exStage (
      .clk      (clk),
      .reset    (reset),
      .inValid  (instrValid),
      .inData   (decoded),
      .outValid (exValid),
      .outData  (exOp)
   );

   executeStage execute (
      .op      (exOp),
      .opValid (exValid),
      .wbWrite (regWrite),
      .result  (exResult)
   );

   pipeStageReg #(.payload_t(wbRecord_t)) wbStage (
      .clk      (clk),
      .reset    (reset),
      .inValid  (exResult.valid),
      .inData   (exResult),
      .outValid (wbValid),
      .outData  (wbData)
   );

   // Valid comes from the reset-cleared bit, the rest from the payload
   assign wb.valid    = wbValid;
   assign wb.illegal  = wbData.illegal;
   assign wb.rd       = wbData.rd;
   assign wb.result   = wbData.result;
   assign wb.writesRd = wbData.writesRd;

   assign regWrite.en   = wb.valid && wb.writesRd && !wb.illegal && (wb.rd != '0);
   assign regWrite.rd   = wb.rd;
   assign regWrite.data = wb.result;

endmodule

// ==== tbAluPipeline.sv ====
`timescale 1ns/1ns

module tbAluPipeline;
   import rvIsaPkg::*;
   import pipePkg::*;

   localparam int clkPeriod   = 4;
   localparam int resetCycles = 5;
   localparam int numDirected = 16;
   localparam int numRandom   = 3000;
   localparam int drainCycles = 2;
   localparam int timeoutNs   =
      (resetCycles + numDirected + numRandom + drainCycles) * clkPeriod + 400;

   logic      clk;
   logic      reset;
   logic      instrValid;
   instr_t    instr;
   wbRecord_t wb;

   int        seed = 90228;
   xdata_t    modelRegs [32];
   wbRecord_t expQ [$];                  // One entry per cycle and idle entries have valid low
   string     nameQ [$];

   aluPipeline dut (
      .clk        (clk),
      .reset      (reset),
      .instrValid (instrValid),
      .instr      (instr),
      .wb         (wb)
   );

   initial begin
      clk = 1'b0;
      forever #(clkPeriod / 2) clk = ~clk;
   end

   initial begin
      #(timeoutNs);
      $display("Timeout: the run went past %0d ns without finishing", timeoutNs);
      $display("Test failed");
      $fatal(1, "Watchdog expired");
   end

   // Codes 0 to 9 are add sub sll slt sltu xor srl sra or and
   function automatic xdata_t aluModel(input int opSel, input xdata_t a, input xdata_t b);
      logic [5:0] sh;
      xdata_t     r;
      sh = b[5:0];
      case (opSel)
         0: r = a + b;
         1: r = a - b;
         2: r = a << sh;
         3: r = ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
         4: r = (a < b) ? 64'd1 : 64'd0;
         5: r = a ^ b;
         6: r = a >> sh;
         7: r = xdata_t'($signed(a) >>> sh);
         8: r = a | b;
         default: r = a & b;
      endcase
      return r;
   endfunction

   function automatic logic [2:0] funct3Of(input int opSel);
      logic [2:0] f3Table [10] = '{3'd0, 3'd0, 3'd1, 3'd2, 3'd3, 3'd4, 3'd5, 3'd5, 3'd6, 3'd7};
      return f3Table[opSel];
   endfunction

   task automatic checkRecord(input string testName, input wbRecord_t exp, input wbRecord_t act);
      logic bad;
      bad = (act.valid !== exp.valid) || (act.illegal !== exp.illegal) ||
            (act.writesRd !== exp.writesRd) || (act.rd !== exp.rd);
      if (!exp.illegal && (act.result !== exp.result)) begin
         bad = 1'b1;                      // Result of an illegal word is not defined
      end
      if (bad) begin
         $write("FAIL %s: expected valid=%0b illegal=%0b rd=%0d wr=%0b result=%h ",
                testName, exp.valid, exp.illegal, exp.rd, exp.writesRd, exp.result);
         $display("actual valid=%0b illegal=%0b rd=%0d wr=%0b result=%h",
                  act.valid, act.illegal, act.rd, act.writesRd, act.result);
         $display("Test failed");
         $fatal(1, "Stopped at the first mismatch");
      end
   endtask

   task automatic checkIdle(input string testName, input wbRecord_t act);
      if (act.valid !== 1'b0) begin
         $display("FAIL %s: expected valid=0 actual valid=%0b", testName, act.valid);
         $display("Test failed");
         $fatal(1, "Stopped at the first mismatch");
      end
   endtask

   // wb sampled here belongs to what was driven two falling edges earlier
   task automatic stepCycle(input logic v, input instr_t word, input wbRecord_t exp,
                            input string testName);
      wbRecord_t e;
      string     n;
      @(negedge clk);
      if (expQ.size() >= 2) begin
         e = expQ.pop_front();
         n = nameQ.pop_front();
         if (e.valid) begin
            checkRecord(n, e, wb);
         end else begin
            checkIdle(n, wb);
         end
      end
      instrValid = v;
      instr      = word;
      expQ.push_back(exp);
      nameQ.push_back(testName);
   endtask

   task automatic issueLegal(input instr_t word, input regIdx_t rd, input xdata_t res,
                             input string testName);
      wbRecord_t exp;
      exp          = '0;
      exp.valid    = 1'b1;
      exp.rd       = rd;
      exp.writesRd = 1'b1;
      exp.result   = res;
      if (rd != 5'd0) begin
         modelRegs[rd] = res;
      end
      stepCycle(1'b1, word, exp, testName);
   endtask

   task automatic issueOp(input int opSel, input regIdx_t rd, input regIdx_t rs1,
                          input regIdx_t rs2, input string testName);
      logic [6:0] f7;
      f7 = (opSel == 1 || opSel == 7) ? 7'b0100000 : 7'b0000000;
      issueLegal({f7, rs2, rs1, funct3Of(opSel), rd, 7'b0110011}, rd,
                 aluModel(opSel, modelRegs[rs1], modelRegs[rs2]), testName);
   endtask

   task automatic issueImm(input int opSel, input regIdx_t rd, input regIdx_t rs1,
                           input logic [11:0] imm12, input string testName);
      xdata_t b;
      b = {{52{imm12[11]}}, imm12};
      issueLegal({imm12, rs1, funct3Of(opSel), rd, 7'b0010011}, rd,
                 aluModel(opSel, modelRegs[rs1], b), testName);
   endtask

   task automatic issueLui(input regIdx_t rd, input logic [19:0] imm20, input string testName);
      issueLegal({imm20, rd, 7'b0110111}, rd, {{32{imm20[19]}}, imm20, 12'b0}, testName);
   endtask

   task automatic issueIllegal(input instr_t word, input string testName);
      wbRecord_t exp;
      exp         = '0;
      exp.valid   = 1'b1;
      exp.illegal = 1'b1;
      exp.rd      = word[11:7];
      stepCycle(1'b1, word, exp, testName);
   endtask

   task automatic idleCycle(input string testName);
      instr_t junk;
      junk = $random(seed);               // Garbage on instr must be ignored while valid is low
      stepCycle(1'b0, junk, '0, testName);
   endtask

   task automatic randomCycle();
      logic [31:0] r;
      logic [31:0] r2;
      int          roll;
      int          opSel;
      regIdx_t     rd;
      regIdx_t     rs1;
      regIdx_t     rs2;
      logic [6:0]  badOp [4] = '{7'b0000011, 7'b0100011, 7'b1100011, 7'b0111011};
      r    = $random(seed);
      r2   = $random(seed);
      roll = int'(r[3:0]);
      rd   = {2'b00, r[6:4]};
      rs1  = {2'b00, r[9:7]};
      rs2  = {2'b00, r[12:10]};
      if (roll < 4) begin
         idleCycle("randomIdle");
      end else if (roll == 4) begin
         case (r[14:13])
            2'd0: issueIllegal({r2[31:7], badOp[r[16:15]]}, "illegalOpcode");
            2'd1: issueIllegal({7'b0000001, r2[24:7], 7'b0110011}, "illegalFunct7");
            2'd2: issueIllegal({6'b100000, r2[5:0], r2[10:6], 3'b001, r2[15:11], 7'b0010011},
                               "illegalShiftImm");
            default: issueIllegal({7'b0100000, r2[9:0], 3'b100, r2[14:10], 7'b0110011},
                                  "illegalAltXor");
         endcase
      end else if (roll < 10) begin
         issueOp(int'(r2[7:0]) % 10, rd, rs1, rs2, "randomOp");
      end else if (roll < 14) begin
         opSel = int'(r2[7:0]) % 9;
         opSel = (opSel == 0) ? 0 : opSel + 1;    // OP-IMM has no sub
         if (opSel == 2 || opSel == 6 || opSel == 7) begin
            issueImm(opSel, rd, rs1, {(opSel == 7) ? 6'b010000 : 6'b000000, r2[13:8]},
                     "randomShiftImm");
         end else begin
            issueImm(opSel, rd, rs1, r2[19:8], "randomOpImm");
         end
      end else begin
         issueLui(rd, r2[31:12], "randomLui");
      end
   endtask

   initial begin
      reset      = 1'b1;
      instrValid = 1'b0;
      instr      = '0;
      for (int i = 0; i < 32; i++) begin
         modelRegs[i] = '0;
      end
      repeat (resetCycles) @(posedge clk);
      @(negedge clk);
      reset = 1'b0;
      expQ.push_back('0);
      nameQ.push_back("afterReset");
      expQ.push_back('0);
      nameQ.push_back("afterReset");

      for (int i = 1; i < 8; i++) begin
         issueOp(0, regIdx_t'(i), regIdx_t'(i), 5'd0, "readBeforeWrite");
      end
      issueImm(0, 5'd0, 5'd0, 12'h005, "writeX0");
      issueOp(0, 5'd1, 5'd0, 5'd0, "x0StaysZero");
      issueImm(0, 5'd1, 5'd1, 12'h7ff, "chainBase");
      issueImm(0, 5'd2, 5'd1, 12'h001, "distance1");
      issueImm(0, 5'd3, 5'd1, 12'h002, "distance2");
      issueImm(0, 5'd4, 5'd1, 12'h003, "distance3");
      issueLui(5'd5, 20'h80000, "luiNegative");
      issueImm(7, 5'd6, 5'd5, {6'b010000, 6'd4}, "sraiNegative");
      issueIllegal(32'hffffffff, "illegalAllOnes");

      repeat (numRandom) randomCycle();
      repeat (drainCycles) idleCycle("drain");

      $display("Test completed successfully");
      $finish;
   end

endmodule

// ==== verilog.f ====
rvIsaPkg.sv
pipePkg.sv
registerFile.sv
instrDecoder.sv
executeStage.sv
pipeStageReg.sv
aluPipeline.sv
tbAluPipeline.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tbAluPipeline
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Test completed successfully
VFLAGS    ?=

.PHONY: simulate clean

simulate:
	$(VERILATOR) --binary --timing --assert --top-module $(TOP) \
		-f $(FILELIST) -Mdir $(BUILD_DIR) $(VFLAGS)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation did not pass, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
